/* m72_bus_config.svh */
`ifndef M72_BUS_CONFIG_SVH
`define M72_BUS_CONFIG_SVH

`define CPU_ADDR_W   20
`define SDR_ADDR_W   24
`define WORD_W       16
`define IO_ADDR_W    8
`define IO_BYTE_W    8
`define AUDIO_W      16

// ROM top per board, byte addresses
`define ROM_END_A    20'h7FFFF
`define ROM_END_B    20'h3FFFF

`define RAM_BASE_A   20'hA0000
`define RAM_BASE_B   20'hE0000
`define RAM_SIZE     20'h04000

`define SDR_RAM_BASE 24'h100000 // Word offset of work RAM

`define IO_SW        8'h00
`define IO_FLAG      8'h02
`define IO_DSW       8'h04

`endif

/* m72_bus_pkg.sv */
`include "m72_bus_config.svh"

package m72_bus_pkg;

    typedef logic [`CPU_ADDR_W-1:0] cpu_addr_t; // Byte address
    typedef logic [`SDR_ADDR_W-1:0] sdr_addr_t; // Word address
    typedef logic [`WORD_W-1:0]     word_t;
    typedef logic [1:0]             byte_sel_t;

    typedef enum logic {
        board_a,
        board_b
    } board_type_t;

    // Request tracking in the SDRAM bridge
    typedef enum logic [1:0] {
        idle,
        wait_ready,
        done
    } bridge_state_t;

endpackage

/* m72_io_pkg.sv */
`include "m72_bus_config.svh"

package m72_io_pkg;

    typedef logic [`IO_ADDR_W-1:0] io_addr_t;
    typedef logic [`IO_BYTE_W-1:0] io_byte_t;

    // Coin counters, flip, color blank
    typedef logic [7:0] sys_flags_t;

    typedef logic signed [`AUDIO_W-1:0] audio_t;

endpackage

/* m72_clock_enables.sv */
`timescale 1ns/100ps

module m72_clock_enables (
    input  logic CLK_32M,
    input  logic reset_n,
    input  logic pause_rq,
    input  logic bus_active,
    input  logic mem_busy,
    output logic paused,
    output logic ce_cpu,
    output logic ce_4x,
    output logic ce_mcu
);

    logic [1:0] cpu_cnt;
    logic [1:0] mcu_cnt;
    logic       started; // Enables start one clock after reset release

    always_ff @(posedge CLK_32M or negedge reset_n) begin
        if (!reset_n) begin
            started <= 1'b0;
            paused  <= 1'b0;
            cpu_cnt <= 2'd0;
            mcu_cnt <= 2'd0;
        end else begin
            started <= 1'b1;

            // Only enter pause between bus cycles
            if (!paused) paused <= pause_rq & ~bus_active & ~mem_busy;
            else         paused <= pause_rq;

            if (ce_4x) cpu_cnt <= cpu_cnt + 2'd1;
            if (!paused) mcu_cnt <= mcu_cnt + 2'd1;
        end
    end

    assign ce_4x  = started & ~paused & ~mem_busy; // Stalled during SDRAM access
    assign ce_cpu = ce_4x & (&cpu_cnt);
    assign ce_mcu = ~paused & (&mcu_cnt);

endmodule

/* m72_region_map.sv */
`timescale 1ns/100ps
`include "m72_bus_config.svh"

module m72_region_map (
    input  m72_bus_pkg::board_type_t board_type,
    input  m72_bus_pkg::cpu_addr_t   addr,
    output logic                     hit,
    output m72_bus_pkg::sdr_addr_t   sdr_addr,
    output logic                     writable
);

    m72_bus_pkg::cpu_addr_t rom_end;
    m72_bus_pkg::cpu_addr_t ram_base;
    m72_bus_pkg::cpu_addr_t ram_offset;
    logic                   in_rom;
    logic                   in_ram;

    assign rom_end  = (board_type == m72_bus_pkg::board_a) ? `ROM_END_A : `ROM_END_B;
    assign ram_base = (board_type == m72_bus_pkg::board_a) ? `RAM_BASE_A : `RAM_BASE_B;

    assign ram_offset = addr - ram_base;
    assign in_rom     = (addr <= rom_end);
    assign in_ram     = (addr >= ram_base) && (ram_offset < `RAM_SIZE);

    always_comb begin
        hit      = 1'b0;
        writable = 1'b0;
        sdr_addr = '0;
        if (in_rom) begin
            hit      = 1'b1;
            sdr_addr = m72_bus_pkg::sdr_addr_t'(addr[`CPU_ADDR_W-1:1]);
        end else if (in_ram) begin
            hit      = 1'b1;
            writable = 1'b1;
            // Work RAM sits above the ROM images
            sdr_addr = `SDR_RAM_BASE +
                       m72_bus_pkg::sdr_addr_t'(ram_offset[`CPU_ADDR_W-1:1]);
        end
    end

endmodule

/* m72_sdram_bridge.sv */
`timescale 1ns/100ps

module m72_sdram_bridge (
    input  logic                     CLK_32M,
    input  logic                     reset_n,
    input  m72_bus_pkg::board_type_t board_type,
    input  logic                     mem_read,
    input  logic                     mem_write,
    input  m72_bus_pkg::cpu_addr_t   mem_addr,
    input  m72_bus_pkg::byte_sel_t   mem_sel,
    input  m72_bus_pkg::word_t       mem_wdata,
    output m72_bus_pkg::word_t       mem_rdata,
    output logic                     mem_busy,
    output m72_bus_pkg::sdr_addr_t   sdr_addr,
    output m72_bus_pkg::word_t       sdr_din,
    output m72_bus_pkg::byte_sel_t   sdr_wr_sel,
    output logic                     sdr_req,
    input  m72_bus_pkg::word_t       sdr_dout,
    input  logic                     sdr_rdy
);

    m72_bus_pkg::bridge_state_t state;
    m72_bus_pkg::sdr_addr_t     region_addr;
    m72_bus_pkg::word_t         rdata_lat;
    m72_bus_pkg::word_t         word_out;
    m72_bus_pkg::byte_sel_t     word_sel;
    logic                       region_hit;
    logic                       region_writable;
    logic                       read_d;
    logic                       write_d;
    logic                       issue;

    m72_region_map u_region_map (
        .board_type (board_type),
        .addr       (mem_addr),
        .hit        (region_hit),
        .sdr_addr   (region_addr),
        .writable   (region_writable)
    );

    // Odd byte goes out on the high lane
    assign word_out = mem_addr[0] ? {mem_wdata[7:0], 8'h00} : mem_wdata;
    assign word_sel = mem_addr[0] ? {mem_sel[0], 1'b0} : mem_sel;

    assign issue = ((mem_read & ~read_d) | (mem_write & ~write_d)) & region_hit &
                   (state != m72_bus_pkg::wait_ready);

    assign mem_busy = (state == m72_bus_pkg::wait_ready);

    always_ff @(posedge CLK_32M or negedge reset_n) begin
        if (!reset_n) begin
            state   <= m72_bus_pkg::idle;
            read_d  <= 1'b0;
            write_d <= 1'b0;
            sdr_req <= 1'b0;
        end else begin
            read_d  <= mem_read;
            write_d <= mem_write;
            sdr_req <= issue; // One cycle strobe
            case (state)
                m72_bus_pkg::wait_ready: if (sdr_rdy) state <= m72_bus_pkg::done;
                default: state <= issue ? m72_bus_pkg::wait_ready : m72_bus_pkg::idle;
            endcase
        end
    end

    always_ff @(posedge CLK_32M) begin
        if (issue) begin
            sdr_addr   <= region_addr;
            sdr_din    <= word_out;
            sdr_wr_sel <= (mem_write & region_writable) ? word_sel : 2'b00;
        end
        if (mem_busy && sdr_rdy) rdata_lat <= sdr_dout;
    end

    // Unmapped space floats high
    assign mem_rdata = !region_hit ? 16'hFFFF :
                       mem_addr[0] ? {8'h00, rdata_lat[15:8]} : rdata_lat;

endmodule

/* m72_io_ports.sv */
`timescale 1ns/100ps
`include "m72_bus_config.svh"

module m72_io_ports (
    input  logic                   CLK_32M,
    input  logic                   reset_n,
    input  logic                   io_read,
    input  logic                   io_write,
    input  m72_io_pkg::io_addr_t   io_addr,
    input  m72_io_pkg::io_byte_t   io_wdata,
    output m72_io_pkg::io_byte_t   io_rdata,
    input  logic [1:0]             coin,
    input  logic [1:0]             start_buttons,
    input  logic [3:0]             p1_joystick,
    input  logic [3:0]             p2_joystick,
    input  logic [3:0]             p1_buttons,
    input  logic [3:0]             p2_buttons,
    input  m72_bus_pkg::word_t     dip_sw,
    output logic [1:0]             coin_counter,
    output logic                   color_blank,
    output logic                   flip
);

    m72_io_pkg::sys_flags_t sys_flags;
    m72_io_pkg::io_addr_t   port;
    m72_bus_pkg::word_t     switches;
    m72_bus_pkg::word_t     flags;
    m72_bus_pkg::word_t     io16;

    assign port     = {io_addr[7:1], 1'b0}; // Word aligned port
    assign switches = {p2_buttons, p2_joystick, p1_buttons, p1_joystick};
    assign flags    = {8'hFF, 4'hF, coin, start_buttons};

    always_comb begin
        io16 = 16'hFFFF;
        if (io_read) begin
            case (port)
                `IO_SW:   io16 = switches;
                `IO_FLAG: io16 = flags;
                `IO_DSW:  io16 = dip_sw;
                default:  io16 = 16'hFFFF;
            endcase
        end
    end

    assign io_rdata = io_addr[0] ? io16[15:8] : io16[7:0];

    always_ff @(posedge CLK_32M or negedge reset_n) begin
        if (!reset_n)
            sys_flags <= '0;
        else if (io_write && io_addr == `IO_FLAG)
            sys_flags <= io_wdata;
    end

    assign coin_counter = sys_flags[1:0];
    assign color_blank  = sys_flags[3];
    assign flip         = ~sys_flags[2] ^ dip_sw[8]; // DIP inverts screen sense

endmodule

/* m72_audio_mix.sv */
`timescale 1ns/100ps

module m72_audio_mix (
    input  logic                 CLK_32M,
    input  logic                 reset_n,
    input  m72_io_pkg::audio_t   ym_audio_l,
    input  m72_io_pkg::audio_t   ym_audio_r,
    input  m72_io_pkg::io_byte_t sample_data,
    output m72_io_pkg::audio_t   audio_l,
    output m72_io_pkg::audio_t   audio_r
);

    m72_io_pkg::io_byte_t signed_sample;
    logic [16:0]          ext_sample;
    logic [16:0]          sum_l;
    logic [16:0]          sum_r;

    assign signed_sample = sample_data - 8'h80; // Offset binary to two's complement
    assign ext_sample    = {signed_sample[7], signed_sample, signed_sample};

    always_ff @(posedge CLK_32M or negedge reset_n) begin
        if (!reset_n) begin
            sum_l <= '0;
            sum_r <= '0;
        end else begin
            sum_l <= {ym_audio_l[15], ym_audio_l} + ext_sample;
            sum_r <= {ym_audio_r[15], ym_audio_r} + ext_sample;
        end
    end

    assign audio_l = sum_l[16:1];
    assign audio_r = sum_r[16:1];

endmodule

/* m72_bus_top.sv */
`timescale 1ns/100ps

module m72_bus_top (
    input  logic                     CLK_32M,
    input  logic                     reset_n,
    input  m72_bus_pkg::board_type_t board_type,

    input  logic                     mem_read,
    input  logic                     mem_write,
    input  m72_bus_pkg::cpu_addr_t   mem_addr,
    input  m72_bus_pkg::byte_sel_t   mem_sel,
    input  m72_bus_pkg::word_t       mem_wdata,
    output m72_bus_pkg::word_t       mem_rdata,

    output m72_bus_pkg::sdr_addr_t   sdr_addr,
    output m72_bus_pkg::word_t       sdr_din,
    output m72_bus_pkg::byte_sel_t   sdr_wr_sel,
    output logic                     sdr_req,
    input  m72_bus_pkg::word_t       sdr_dout,
    input  logic                     sdr_rdy,

    input  logic                     io_read,
    input  logic                     io_write,
    input  m72_io_pkg::io_addr_t     io_addr,
    input  m72_io_pkg::io_byte_t     io_wdata,
    output m72_io_pkg::io_byte_t     io_rdata,

    input  logic [1:0]               coin,
    input  logic [1:0]               start_buttons,
    input  logic [3:0]               p1_joystick,
    input  logic [3:0]               p2_joystick,
    input  logic [3:0]               p1_buttons,
    input  logic [3:0]               p2_buttons,
    input  m72_bus_pkg::word_t       dip_sw,

    input  logic                     pause_rq,
    output logic                     paused,
    output logic                     ce_cpu,
    output logic                     ce_4x,
    output logic                     ce_mcu,
    output logic [1:0]               coin_counter,
    output logic                     color_blank,
    output logic                     flip,

    input  m72_io_pkg::audio_t       ym_audio_l,
    input  m72_io_pkg::audio_t       ym_audio_r,
    input  m72_io_pkg::io_byte_t     sample_data,
    output m72_io_pkg::audio_t       audio_l,
    output m72_io_pkg::audio_t       audio_r
);

    logic mem_busy;

    m72_clock_enables u_clock_enables (
        .CLK_32M    (CLK_32M),
        .reset_n    (reset_n),
        .pause_rq   (pause_rq),
        .bus_active (mem_read | mem_write | io_read | io_write),
        .mem_busy   (mem_busy),
        .paused     (paused),
        .ce_cpu     (ce_cpu),
        .ce_4x      (ce_4x),
        .ce_mcu     (ce_mcu)
    );

    m72_sdram_bridge u_sdram_bridge (
        .CLK_32M    (CLK_32M),
        .reset_n    (reset_n),
        .board_type (board_type),
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .mem_addr   (mem_addr),
        .mem_sel    (mem_sel),
        .mem_wdata  (mem_wdata),
        .mem_rdata  (mem_rdata),
        .mem_busy   (mem_busy),
        .sdr_addr   (sdr_addr),
        .sdr_din    (sdr_din),
        .sdr_wr_sel (sdr_wr_sel),
        .sdr_req    (sdr_req),
        .sdr_dout   (sdr_dout),
        .sdr_rdy    (sdr_rdy)
    );

    m72_io_ports u_io_ports (
        .CLK_32M       (CLK_32M),
        .reset_n       (reset_n),
        .io_read       (io_read),
        .io_write      (io_write),
        .io_addr       (io_addr),
        .io_wdata      (io_wdata),
        .io_rdata      (io_rdata),
        .coin          (coin),
        .start_buttons (start_buttons),
        .p1_joystick   (p1_joystick),
        .p2_joystick   (p2_joystick),
        .p1_buttons    (p1_buttons),
        .p2_buttons    (p2_buttons),
        .dip_sw        (dip_sw),
        .coin_counter  (coin_counter),
        .color_blank   (color_blank),
        .flip          (flip)
    );

    m72_audio_mix u_audio_mix (
        .CLK_32M     (CLK_32M),
        .reset_n     (reset_n),
        .ym_audio_l  (ym_audio_l),
        .ym_audio_r  (ym_audio_r),
        .sample_data (sample_data),
        .audio_l     (audio_l),
        .audio_r     (audio_r)
    );

endmodule

/* tb_m72_bus.sv */
`timescale 1ns/100ps
`include "m72_bus_config.svh"

module tb_m72_bus;

    localparam int TIMEOUT_CYCLES = 20000; // All tests need well under 2000 cycles
    localparam int BUSY_LIMIT     = 40;

    logic                     CLK_32M;
    logic                     reset_n;
    m72_bus_pkg::board_type_t board_type;
    logic                     mem_read;
    logic                     mem_write;
    m72_bus_pkg::cpu_addr_t   mem_addr;
    m72_bus_pkg::byte_sel_t   mem_sel;
    m72_bus_pkg::word_t       mem_wdata;
    m72_bus_pkg::word_t       mem_rdata;
    m72_bus_pkg::sdr_addr_t   sdr_addr;
    m72_bus_pkg::word_t       sdr_din;
    m72_bus_pkg::byte_sel_t   sdr_wr_sel;
    logic                     sdr_req;
    m72_bus_pkg::word_t       sdr_dout;
    logic                     sdr_rdy;
    logic                     io_read;
    logic                     io_write;
    m72_io_pkg::io_addr_t     io_addr;
    m72_io_pkg::io_byte_t     io_wdata;
    m72_io_pkg::io_byte_t     io_rdata;
    logic [1:0]               coin;
    logic [1:0]               start_buttons;
    logic [3:0]               p1_joystick;
    logic [3:0]               p2_joystick;
    logic [3:0]               p1_buttons;
    logic [3:0]               p2_buttons;
    m72_bus_pkg::word_t       dip_sw;
    logic                     pause_rq;
    logic                     paused;
    logic                     ce_cpu;
    logic                     ce_4x;
    logic                     ce_mcu;
    logic [1:0]               coin_counter;
    logic                     color_blank;
    logic                     flip;
    m72_io_pkg::audio_t       ym_audio_l;
    m72_io_pkg::audio_t       ym_audio_r;
    m72_io_pkg::io_byte_t     sample_data;
    m72_io_pkg::audio_t       audio_l;
    m72_io_pkg::audio_t       audio_r;

    int                       value_errors;
    int                       other_failures;
    logic [31:0]              rng_state;

    // SDRAM model state
    m72_bus_pkg::word_t       sdram [m72_bus_pkg::sdr_addr_t];
    int                       req_count;
    m72_bus_pkg::sdr_addr_t   last_addr;
    m72_bus_pkg::word_t       last_din;
    m72_bus_pkg::byte_sel_t   last_sel;
    m72_bus_pkg::word_t       model_word;
    int                       model_delay;

    m72_bus_top DUT (.*);

    always #20 CLK_32M = ~CLK_32M;

    function automatic logic [31:0] next_random();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic m72_io_pkg::audio_t mix_expected(m72_io_pkg::audio_t ym,
                                                        logic [7:0] smp);
        int          centred;
        int          extended;
        int          sum;
        logic [31:0] half;
        centred  = int'(smp) - 128; // Offset binary to signed
        // Sign above, the same byte repeated below
        extended = centred * 256 + ((centred + 256) % 256);
        sum      = int'(ym) + extended;
        half     = sum >>> 1;
        return half[15:0];
    endfunction

    // Unwritten words read back as the low half of their address
    always begin
        @(posedge CLK_32M);
        #1;
        if (sdr_req === 1'b1) begin
            req_count  = req_count + 1;
            last_addr  = sdr_addr;
            last_din   = sdr_din;
            last_sel   = sdr_wr_sel;
            model_word = sdram.exists(sdr_addr) ? sdram[sdr_addr] : sdr_addr[15:0];
            if (sdr_wr_sel[0]) model_word[7:0] = sdr_din[7:0];
            if (sdr_wr_sel[1]) model_word[15:8] = sdr_din[15:8];
            if (sdr_wr_sel != 2'b00) sdram[sdr_addr] = model_word;
            model_delay = 1 + (next_random() % 6);
            repeat (model_delay) @(posedge CLK_32M);
            #2;
            sdr_dout = model_word;
            sdr_rdy  = 1'b1;
            @(posedge CLK_32M);
            #2;
            sdr_rdy  = 1'b0;
        end
    end

    task automatic tick();
        @(posedge CLK_32M);
        #2;
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("Error: %s = %h, expected %h", name, got, exp);
        value_errors = value_errors + 1;
    endtask

    task automatic mem_access(input logic wr, input m72_bus_pkg::cpu_addr_t addr,
                              input m72_bus_pkg::byte_sel_t sel,
                              input m72_bus_pkg::word_t wdata, input logic expect_hit,
                              output m72_bus_pkg::word_t rdata);
        int start_count;
        int waited;
        start_count = req_count;
        mem_addr    = addr;
        mem_sel     = sel;
        mem_wdata   = wdata;
        mem_read    = ~wr;
        mem_write   = wr;
        tick();
        if (mem_busy_now() !== expect_hit) report_mismatch("mem_busy", mem_busy_now(), expect_hit);
        waited = 0;
        while (mem_busy_now() && waited < BUSY_LIMIT) begin
            if (ce_4x !== 1'b0) report_mismatch("ce_4x", ce_4x, 0);
            tick();
            waited = waited + 1;
        end
        if (waited >= BUSY_LIMIT) begin
            $display("Memory access at %h never completed", addr);
            other_failures = other_failures + 1;
        end
        if (!expect_hit) repeat (2) tick(); // Make sure no late request appears
        if (req_count != start_count + (expect_hit ? 1 : 0))
            report_mismatch("sdr_req count", req_count - start_count, expect_hit);
        rdata     = mem_rdata;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        tick();
    endtask

    function automatic logic mem_busy_now();
        return DUT.mem_busy;
    endfunction

    task automatic verify_request(input m72_bus_pkg::sdr_addr_t exp_addr,
                                  input m72_bus_pkg::byte_sel_t exp_sel,
                                  input m72_bus_pkg::word_t exp_din);
        if (last_addr !== exp_addr) report_mismatch("sdr_addr", last_addr, exp_addr);
        if (last_sel !== exp_sel) report_mismatch("sdr_wr_sel", last_sel, exp_sel);
        if (exp_sel != 2'b00 && last_din !== exp_din)
            report_mismatch("sdr_din", last_din, exp_din);
    endtask

    task automatic read_rom_word(input m72_bus_pkg::cpu_addr_t addr);
        m72_bus_pkg::word_t rd;
        m72_bus_pkg::word_t word;
        m72_bus_pkg::word_t exp;
        mem_access(1'b0, addr, 2'b11, 16'h0000, 1'b1, rd);
        verify_request({5'h00, addr[19:1]}, 2'b00, 16'h0000);
        word = addr[16:1]; // Model fill value
        exp  = addr[0] ? {8'h00, word[15:8]} : word;
        if (rd !== exp) report_mismatch("mem_rdata", rd, exp);
    endtask

    task automatic rom_reads_board_a();
        m72_bus_pkg::word_t rd;
        board_type = m72_bus_pkg::board_a;
        read_rom_word(20'h00100);
        read_rom_word(20'h12345);
        read_rom_word(20'h7FFF0);
        read_rom_word(20'h7FFF1);
        mem_access(1'b0, 20'h90000, 2'b11, 16'h0000, 1'b0, rd);
        if (rd !== 16'hFFFF) report_mismatch("mem_rdata", rd, 16'hFFFF);
    endtask

    task automatic ram_write_readback();
        m72_bus_pkg::word_t     rd;
        m72_bus_pkg::word_t     merged;
        m72_bus_pkg::sdr_addr_t wa_word;
        m72_bus_pkg::sdr_addr_t wa_byte;
        board_type = m72_bus_pkg::board_b;
        wa_word = `SDR_RAM_BASE + ((20'hE0010 - `RAM_BASE_B) >> 1);
        wa_byte = `SDR_RAM_BASE + ((20'hE0020 - `RAM_BASE_B) >> 1);
        mem_access(1'b1, 20'hE0010, 2'b11, 16'h1234, 1'b1, rd);
        verify_request(wa_word, 2'b11, 16'h1234);
        mem_access(1'b1, 20'hE0020, 2'b01, 16'h00AB, 1'b1, rd);
        verify_request(wa_byte, 2'b01, 16'h00AB);
        // Odd byte moves to the high lane
        mem_access(1'b1, 20'hE0021, 2'b01, 16'h00CD, 1'b1, rd);
        verify_request(wa_byte, 2'b10, 16'hCD00);
        mem_access(1'b1, 20'h01000, 2'b11, 16'h5555, 1'b1, rd);
        verify_request(24'h000800, 2'b00, 16'h0000);

        merged = {8'hCD, 8'hAB};
        mem_access(1'b0, 20'hE0010, 2'b11, 16'h0000, 1'b1, rd);
        if (rd !== 16'h1234) report_mismatch("mem_rdata", rd, 16'h1234);
        mem_access(1'b0, 20'hE0020, 2'b11, 16'h0000, 1'b1, rd);
        if (rd !== merged) report_mismatch("mem_rdata", rd, merged);
        mem_access(1'b0, 20'hE0021, 2'b11, 16'h0000, 1'b1, rd);
        if (rd !== 16'h00CD) report_mismatch("mem_rdata", rd, 16'h00CD);
        mem_access(1'b0, 20'h01000, 2'b11, 16'h0000, 1'b1, rd);
        if (rd !== 16'h0800) report_mismatch("mem_rdata", rd, 16'h0800); // ROM untouched
    endtask

    task automatic expect_io_byte(input logic [7:0] port, input logic [7:0] exp);
        io_addr = port;
        io_read = 1'b1;
        tick();
        if (io_rdata !== exp) report_mismatch("io_rdata", io_rdata, exp);
        io_read = 1'b0;
    endtask

    task automatic io_port_reads();
        logic [31:0] r;
        logic [15:0] sw;
        logic [15:0] fl;
        r = next_random();
        {p2_buttons, p2_joystick, p1_buttons, p1_joystick} = r[15:0];
        {coin, start_buttons} = r[19:16];
        dip_sw = next_random();
        sw = {p2_buttons, p2_joystick, p1_buttons, p1_joystick};
        fl = {8'hFF, 4'hF, coin, start_buttons};
        expect_io_byte(8'h00, sw[7:0]);
        expect_io_byte(8'h01, sw[15:8]);
        expect_io_byte(8'h02, fl[7:0]);
        expect_io_byte(8'h03, fl[15:8]);
        expect_io_byte(8'h04, dip_sw[7:0]);
        expect_io_byte(8'h05, dip_sw[15:8]);
        expect_io_byte(8'h10, 8'hFF);
    endtask

    task automatic sys_flag_writes();
        logic [7:0] v;
        logic       exp_flip;
        for (int d = 0; d < 2; d++) begin
            dip_sw[8] = d[0];
            for (int i = 0; i < 6; i++) begin
                v        = next_random();
                exp_flip = ~v[2] ^ d[0];
                io_addr  = `IO_FLAG;
                io_wdata = v;
                io_write = 1'b1;
                tick();
                io_write = 1'b0;
                if (coin_counter !== v[1:0]) report_mismatch("coin_counter", coin_counter, v[1:0]);
                if (color_blank !== v[3]) report_mismatch("color_blank", color_blank, v[3]);
                if (flip !== exp_flip) report_mismatch("flip", flip, exp_flip);
            end
        end
    endtask

    task automatic enables_and_pause();
        int last_cpu;
        int cpu_hits;
        int mcu_hits;
        int waited;
        logic [15:0] rd;
        last_cpu = -1;
        cpu_hits = 0;
        mcu_hits = 0;
        for (int i = 0; i < 16; i++) begin
            if (ce_4x !== 1'b1) report_mismatch("ce_4x", ce_4x, 1);
            if (ce_cpu === 1'b1) begin
                if (last_cpu >= 0 && i - last_cpu != 4)
                    report_mismatch("ce_cpu spacing", i - last_cpu, 4);
                last_cpu = i;
                cpu_hits = cpu_hits + 1;
            end
            if (ce_mcu === 1'b1) mcu_hits = mcu_hits + 1;
            tick();
        end
        if (cpu_hits != 4) report_mismatch("ce_cpu count", cpu_hits, 4);
        if (mcu_hits != 4) report_mismatch("ce_mcu count", mcu_hits, 4);
        mem_access(1'b0, 20'h00200, 2'b11, 16'h0000, 1'b1, rd); // ce_4x checked while busy

        // No pause while an I/O strobe is up
        io_addr  = 8'h10;
        io_read  = 1'b1;
        pause_rq = 1'b1;
        repeat (3) begin
            tick();
            if (paused !== 1'b0) report_mismatch("paused", paused, 0);
        end
        io_read = 1'b0;
        waited  = 0;
        while (paused !== 1'b1 && waited < 10) begin
            tick();
            waited = waited + 1;
        end
        if (paused !== 1'b1) begin
            $display("Pause request was never granted");
            other_failures = other_failures + 1;
        end
        repeat (8) begin
            if ({ce_cpu, ce_4x, ce_mcu} !== 3'b000)
                report_mismatch("ce_cpu/ce_4x/ce_mcu", {ce_cpu, ce_4x, ce_mcu}, 0);
            tick();
        end
        pause_rq = 1'b0;
        waited   = 0;
        while (paused !== 1'b0 && waited < 10) begin
            tick();
            waited = waited + 1;
        end
        cpu_hits = 0;
        mcu_hits = 0;
        repeat (8) begin
            if (ce_4x !== 1'b1) report_mismatch("ce_4x", ce_4x, 1);
            if (ce_cpu === 1'b1) cpu_hits = cpu_hits + 1;
            if (ce_mcu === 1'b1) mcu_hits = mcu_hits + 1;
            tick();
        end
        if (cpu_hits != 2) report_mismatch("ce_cpu count after pause", cpu_hits, 2);
        if (mcu_hits != 2) report_mismatch("ce_mcu count after pause", mcu_hits, 2);
    endtask

    task automatic audio_mix_random();
        m72_io_pkg::audio_t exp_l;
        m72_io_pkg::audio_t exp_r;
        for (int i = 0; i < 12; i++) begin
            ym_audio_l  = next_random();
            ym_audio_r  = next_random();
            sample_data = next_random();
            exp_l       = mix_expected(ym_audio_l, sample_data);
            exp_r       = mix_expected(ym_audio_r, sample_data);
            tick();
            if (audio_l !== exp_l) report_mismatch("audio_l", audio_l, exp_l);
            if (audio_r !== exp_r) report_mismatch("audio_r", audio_r, exp_r);
        end
    endtask

    initial begin
        CLK_32M        = 1'b0;
        reset_n        = 1'b0;
        board_type     = m72_bus_pkg::board_a;
        mem_read       = 1'b0;
        mem_write      = 1'b0;
        mem_addr       = '0;
        mem_sel        = 2'b00;
        mem_wdata      = '0;
        sdr_dout       = '0;
        sdr_rdy        = 1'b0;
        io_read        = 1'b0;
        io_write       = 1'b0;
        io_addr        = '0;
        io_wdata       = '0;
        coin           = 2'b11;
        start_buttons  = 2'b11;
        p1_joystick    = 4'hF;
        p2_joystick    = 4'hF;
        p1_buttons     = 4'hF;
        p2_buttons     = 4'hF;
        dip_sw         = 16'hFFFF;
        pause_rq       = 1'b0;
        ym_audio_l     = '0;
        ym_audio_r     = '0;
        sample_data    = 8'h80;
        value_errors   = 0;
        other_failures = 0;
        req_count      = 0;
        rng_state      = 32'd19;

        repeat (10) @(posedge CLK_32M);
        #2;
        reset_n = 1'b1;
        repeat (3) tick();

        io_port_reads();
        sys_flag_writes();
        rom_reads_board_a();
        ram_write_readback();
        enables_and_pause();
        audio_mix_random();

        $display("Summary: %0d value errors, %0d other failures", value_errors, other_failures);
        if (value_errors == 0 && other_failures == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge CLK_32M);
        $display("Watchdog expired after %0d cycles, run stopped", TIMEOUT_CYCLES);
        $display("Finished with errors");
        $finish;
    end

endmodule

/* flist.f */
+incdir+.
m72_bus_pkg.sv
m72_io_pkg.sv
m72_clock_enables.sv
m72_region_map.sv
m72_sdram_bridge.sv
m72_io_ports.sv
m72_audio_mix.sv
m72_bus_top.sv
tb_m72_bus.sv
